//--- source/rvTypes.sv
// RV32I shared types
package rvTypes;

    typedef logic [31:0] dataT;     // Data word
    typedef logic [31:0] instT;     // Instruction word
    typedef logic [4:0]  regAddrT;  // Register index

    // ALU operations
    typedef enum logic [3:0] {
        Add, Sub, And, Or, Xor,
        Slt, Sltu,                  // Signed / unsigned set-less-than
        Sll, Srl, Sra,
        PassB                       // Operand B straight through, for LUI
    } AluOp;

    // Next PC source
    typedef enum logic [1:0] {
        PcPlus4    = 2'd0,
        PcPlusImm  = 2'd1,          // Taken branch and JAL
        Rs1PlusImm = 2'd2           // JALR
    } PcSel;

    // Register write-back source
    typedef enum logic [1:0] {
        WbAlu     = 2'd0,
        WbMem     = 2'd1,
        WbPcPlus4 = 2'd2            // Link address
    } WbSel;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111
    } Opcode;

endpackage

//--- source/memBus.sv
// Data memory bus
`timescale 1ns/1ps

interface memBus;
    import rvTypes::*;

    dataT addr;      // Byte address
    logic wrEnable;  // Write strobe, sampled at the rising edge
    dataT wrData;
    dataT rdData;    // Follows addr in the same cycle

    // Processor side
    modport master (output addr, output wrEnable, output wrData, input rdData);

    // Memory side
    modport slave (input addr, input wrEnable, input wrData, output rdData);

endinterface

//--- source/Controller_RV32I.sv
// RV32I control decoder
`timescale 1ns/1ps

module Controller_RV32I (
    input  rvTypes::instT i_Inst,
    input  logic          i_IsEQ,         // rs1 == rs2
    input  logic          i_IsLT,         // rs1 < rs2, signed
    input  logic          i_IsLTU,        // rs1 < rs2, unsigned
    output rvTypes::AluOp o_AluControl,
    output logic          o_MemWrEnable,
    output logic          o_RegWrEnable,
    output logic          o_OperandASel,  // 1 selects the PC
    output logic          o_OperandBSel,  // 1 selects the immediate
    output rvTypes::WbSel o_RegWrDataSel,
    output rvTypes::PcSel o_PCNextSel);

    import rvTypes::*;

    logic [2:0] funct3;
    logic       funct7Alt;     // Bit 30, SUB and SRA
    logic       isRegOp;
    logic       branchTaken;
    AluOp       funcOp;        // Operation named by funct3

    assign funct3    = i_Inst[14:12];
    assign funct7Alt = i_Inst[30];
    assign isRegOp   = i_Inst[6:0] == OpReg;

    // ALU operation named by funct3
    always_comb begin
        case (funct3)
            3'b000: begin
                if (isRegOp && funct7Alt)
                    funcOp = Sub;      // SUB only in R format
                else
                    funcOp = Add;
            end
            3'b001: funcOp = Sll;
            3'b010: funcOp = Slt;
            3'b011: funcOp = Sltu;
            3'b100: funcOp = Xor;
            3'b101: begin
                if (funct7Alt)
                    funcOp = Sra;      // Also SRAI
                else
                    funcOp = Srl;
            end
            3'b110: funcOp = Or;
            default: funcOp = And;
        endcase
    end

    // Branch condition from the comparison flags
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = i_IsEQ;    // BEQ
            3'b001:  branchTaken = ~i_IsEQ;   // BNE
            3'b100:  branchTaken = i_IsLT;    // BLT
            3'b101:  branchTaken = ~i_IsLT;   // BGE
            3'b110:  branchTaken = i_IsLTU;   // BLTU
            3'b111:  branchTaken = ~i_IsLTU;  // BGEU
            default: branchTaken = 1'b0;      // Reserved encodings never branch
        endcase
    end

    // Datapath control per opcode
    always_comb begin
        o_AluControl   = Add;
        o_MemWrEnable  = 1'b0;
        o_RegWrEnable  = 1'b0;
        o_OperandASel  = 1'b0;
        o_OperandBSel  = 1'b0;
        o_RegWrDataSel = WbAlu;
        o_PCNextSel    = PcPlus4;
        case (Opcode'(i_Inst[6:0]))
            OpReg: begin
                o_RegWrEnable = 1'b1;
                o_AluControl  = funcOp;
            end
            OpImm: begin
                o_RegWrEnable = 1'b1;
                o_AluControl  = funcOp;
                o_OperandBSel = 1'b1;
            end
            OpLoad: begin
                o_RegWrEnable  = 1'b1;
                o_OperandBSel  = 1'b1;        // Address is rs1 plus offset
                o_RegWrDataSel = WbMem;
            end
            OpStore: begin
                o_MemWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
            end
            OpBranch: begin
                if (branchTaken)
                    o_PCNextSel = PcPlusImm;
            end
            OpJal: begin
                o_RegWrEnable  = 1'b1;
                o_RegWrDataSel = WbPcPlus4;   // Link
                o_PCNextSel    = PcPlusImm;
            end
            OpJalr: begin
                o_RegWrEnable  = 1'b1;
                o_RegWrDataSel = WbPcPlus4;
                o_PCNextSel    = Rs1PlusImm;
            end
            OpLui: begin
                o_RegWrEnable = 1'b1;
                o_AluControl  = PassB;
                o_OperandBSel = 1'b1;
            end
            OpAuipc: begin
                o_RegWrEnable = 1'b1;
                o_OperandASel = 1'b1;         // PC plus upper immediate
                o_OperandBSel = 1'b1;
            end
            default: o_PCNextSel = PcPlus4;   // Unknown opcode acts as a no-op
        endcase
    end

    // A store never writes back
    always_comb begin
        memRegExclusive: assert (!(o_MemWrEnable && o_RegWrEnable));
    end

endmodule

//--- source/Decoder_RV32I.sv
// RV32I field and immediate decoder
`timescale 1ns/1ps

module Decoder_RV32I (
    input  rvTypes::instT    i_Inst,
    output rvTypes::regAddrT o_RS1,
    output rvTypes::regAddrT o_RS2,
    output rvTypes::regAddrT o_RD,
    output rvTypes::dataT    o_IMM);

    import rvTypes::*;

    // Register fields sit at fixed positions in every format
    assign o_RS1 = i_Inst[19:15];
    assign o_RS2 = i_Inst[24:20];
    assign o_RD  = i_Inst[11:7];

    // Immediate format follows the opcode
    always_comb begin
        case (Opcode'(i_Inst[6:0]))
            OpImm, OpLoad, OpJalr:            // I format
                o_IMM = {{20{i_Inst[31]}}, i_Inst[31:20]};
            OpStore:                          // S format
                o_IMM = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            OpBranch:                         // B format, bit 0 always zero
                o_IMM = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7],
                         i_Inst[30:25], i_Inst[11:8], 1'b0};
            OpLui, OpAuipc:                   // U format
                o_IMM = {i_Inst[31:12], 12'b0};
            OpJal:                            // J format
                o_IMM = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12],
                         i_Inst[20], i_Inst[30:21], 1'b0};
            default:
                o_IMM = '0;                   // R format has none
        endcase
    end

endmodule

//--- source/RegisterFile.sv
// Integer register file
`timescale 1ns/1ps

module RegisterFile (
    input  logic             i_Clock,
    input  logic             i_rst,
    input  logic             i_WrEnable,
    input  rvTypes::regAddrT i_WrAddr,
    input  rvTypes::dataT    i_WrData,
    input  rvTypes::regAddrT i_RdAddrA,
    input  rvTypes::regAddrT i_RdAddrB,
    output rvTypes::dataT    o_RdDataA,
    output rvTypes::dataT    o_RdDataB);

    import rvTypes::*;

    dataT regs [32];

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (i_WrEnable && i_WrAddr != '0) begin  // x0 writes dropped
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Asynchronous reads
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

    // x0 must hold zero through any instruction sequence
    x0Zero: assert property (@(posedge i_Clock) disable iff (i_rst) regs[0] == '0);

endmodule

//--- source/Alu.sv
// Integer ALU and branch comparator
`timescale 1ns/1ps

module Alu (
    input  rvTypes::AluOp i_Op,
    input  rvTypes::dataT i_OperandA,
    input  rvTypes::dataT i_OperandB,
    input  rvTypes::dataT i_CompA,     // rs1 for branches
    input  rvTypes::dataT i_CompB,     // rs2 for branches
    output rvTypes::dataT o_Result,
    output logic          o_EQ,
    output logic          o_LT,
    output logic          o_LTU);

    import rvTypes::*;

    logic [4:0] shamt;
    assign shamt = i_OperandB[4:0];    // Shift amount, low five bits only

    always_comb begin
        case (i_Op)
            Add:     o_Result = i_OperandA + i_OperandB;
            Sub:     o_Result = i_OperandA - i_OperandB;
            And:     o_Result = i_OperandA & i_OperandB;
            Or:      o_Result = i_OperandA | i_OperandB;
            Xor:     o_Result = i_OperandA ^ i_OperandB;
            Slt:     o_Result = dataT'($signed(i_OperandA) < $signed(i_OperandB));
            Sltu:    o_Result = dataT'(i_OperandA < i_OperandB);
            Sll:     o_Result = i_OperandA << shamt;
            Srl:     o_Result = i_OperandA >> shamt;
            Sra:     o_Result = $unsigned($signed(i_OperandA) >>> shamt);  // Sign fill
            PassB:   o_Result = i_OperandB;
            default: o_Result = '0;
        endcase
    end

    // Branch flags, independent of the selected operation
    assign o_EQ  = i_CompA == i_CompB;
    assign o_LT  = $signed(i_CompA) < $signed(i_CompB);
    assign o_LTU = i_CompA < i_CompB;

endmodule

//--- source/ProcessorSC.sv
// Single-cycle RV32I datapath
`timescale 1ns/1ps

module ProcessorSC #(
    parameter PC_WIDTH = 32)
(
    input  logic                i_Clock,
    input  logic                i_rst,
    output logic [PC_WIDTH-1:0] o_PgmAddr,   // Instruction byte address
    input  rvTypes::instT       i_PgmInst,
    memBus.master               dataBus);

    import rvTypes::*;

    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] pcNext;
    logic [PC_WIDTH-1:0] pcPlus4;
    logic [PC_WIDTH-1:0] pcPlusImm;    // Branch and JAL target
    logic [PC_WIDTH-1:0] rs1PlusImm;   // Raw JALR sum
    logic [PC_WIDTH-1:0] jalrTarget;

    AluOp ctrlAluOp;
    logic ctrlMemWr, ctrlRegWr;
    logic ctrlOpASel, ctrlOpBSel;
    WbSel ctrlWbSel;
    PcSel ctrlPcSel;

    regAddrT rs1, rs2, rd;
    dataT    imm;
    dataT    rdDataA, rdDataB;         // Register read values
    dataT    operandA, operandB;
    dataT    aluResult;
    dataT    wbData;
    logic    isEQ, isLT, isLTU;

    Controller_RV32I ctrl (
        .i_Inst         (i_PgmInst),
        .i_IsEQ         (isEQ),
        .i_IsLT         (isLT),
        .i_IsLTU        (isLTU),
        .o_AluControl   (ctrlAluOp),
        .o_MemWrEnable  (ctrlMemWr),
        .o_RegWrEnable  (ctrlRegWr),
        .o_OperandASel  (ctrlOpASel),
        .o_OperandBSel  (ctrlOpBSel),
        .o_RegWrDataSel (ctrlWbSel),
        .o_PCNextSel    (ctrlPcSel));

    Decoder_RV32I dec (
        .i_Inst (i_PgmInst),
        .o_RS1  (rs1),
        .o_RS2  (rs2),
        .o_RD   (rd),
        .o_IMM  (imm));

    RegisterFile regs (
        .i_Clock    (i_Clock),
        .i_rst      (i_rst),
        .i_WrEnable (ctrlRegWr),
        .i_WrAddr   (rd),
        .i_WrData   (wbData),
        .i_RdAddrA  (rs1),
        .i_RdAddrB  (rs2),
        .o_RdDataA  (rdDataA),
        .o_RdDataB  (rdDataB));

    // Operand A is the PC only for AUIPC
    assign operandA = ctrlOpASel ? dataT'(pc) : rdDataA;
    assign operandB = ctrlOpBSel ? imm : rdDataB;

    Alu aluUnit (
        .i_Op       (ctrlAluOp),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .i_CompA    (rdDataA),
        .i_CompB    (rdDataB),
        .o_Result   (aluResult),
        .o_EQ       (isEQ),
        .o_LT       (isLT),
        .o_LTU      (isLTU));

    // Next PC candidates
    assign pcPlus4    = pc + PC_WIDTH'(4);
    assign pcPlusImm  = pc + imm[PC_WIDTH-1:0];
    assign rs1PlusImm = rdDataA[PC_WIDTH-1:0] + imm[PC_WIDTH-1:0];
    assign jalrTarget = {rs1PlusImm[PC_WIDTH-1:1], 1'b0};  // LSB cleared

    always_comb begin
        case (ctrlPcSel)
            PcPlusImm:  pcNext = pcPlusImm;
            Rs1PlusImm: pcNext = jalrTarget;
            default:    pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (i_rst)
            pc <= '0;          // Fetch starts at address 0
        else
            pc <= pcNext;
    end

    // Write-back source
    always_comb begin
        case (ctrlWbSel)
            WbMem:     wbData = dataBus.rdData;
            WbPcPlus4: wbData = dataT'(pcPlus4);  // Link address
            default:   wbData = aluResult;
        endcase
    end

    // Data bus, address from the ALU and store data from rs2
    assign dataBus.addr     = aluResult;
    assign dataBus.wrData   = rdDataB;
    assign dataBus.wrEnable = ctrlMemWr & ~i_rst;  // No stray store while held in reset

    assign o_PgmAddr = pc;

    // A misaligned JALR target would break fetch
    pcAligned: assert property (@(posedge i_Clock) disable iff (i_rst)
        o_PgmAddr[1:0] == 2'b00);

endmodule

//--- source/ProgramRom.sv
// Program memory
`timescale 1ns/1ps

module ProgramRom #(
    parameter PC_WIDTH      = 32,
    parameter PGM_ADDR_BITS = 8)
(
    input  logic                     i_Clock,
    input  logic                     i_WrEnable,  // Load port strobe
    input  logic [PGM_ADDR_BITS-1:0] i_WrAddr,    // Word address
    input  rvTypes::instT            i_WrData,
    input  logic [PC_WIDTH-1:0]      i_Addr,      // Fetch byte address
    output rvTypes::instT            o_Inst);

    import rvTypes::*;

    instT mem [2**PGM_ADDR_BITS];

    // Loaded one word per edge
    always_ff @(posedge i_Clock) begin
        if (i_WrEnable)
            mem[i_WrAddr] <= i_WrData;
    end

    assign o_Inst = mem[i_Addr[PGM_ADDR_BITS+1:2]];  // Byte to word index

endmodule

//--- source/DataRam.sv
// Word-wide data RAM
`timescale 1ns/1ps

module DataRam #(
    parameter DATA_ADDR_BITS = 8)
(
    input  logic  i_Clock,
    memBus.slave  bus);

    import rvTypes::*;

    dataT                      mem [2**DATA_ADDR_BITS];
    logic [DATA_ADDR_BITS-1:0] wordAddr;

    // Low two bits select a byte, ignored for word access
    assign wordAddr = bus.addr[DATA_ADDR_BITS+1:2];

    always_ff @(posedge i_Clock) begin
        if (bus.wrEnable)
            mem[wordAddr] <= bus.wrData;
    end

    assign bus.rdData = mem[wordAddr];  // Same-cycle read

endmodule

//--- source/ProcessorSys.sv
// RV32I processor system
`timescale 1ns/1ps

module ProcessorSys #(
    parameter PC_WIDTH       = 32,
    parameter PGM_ADDR_BITS  = 8,
    parameter DATA_ADDR_BITS = 8)
(
    input  logic                     i_Clock,
    input  logic                     i_rst,
    input  logic                     i_PgmWrEnable,  // Program load, only under reset
    input  logic [PGM_ADDR_BITS-1:0] i_PgmWrAddr,
    input  rvTypes::instT            i_PgmWrData,
    output logic                     o_StoreValid,   // One cycle per executed SW
    output rvTypes::dataT            o_StoreAddr,
    output rvTypes::dataT            o_StoreData);

    logic [PC_WIDTH-1:0] pgmAddr;
    rvTypes::instT       pgmInst;

    memBus dataBus ();

    ProcessorSC #(
        .PC_WIDTH (PC_WIDTH))
    cpu (
        .i_Clock   (i_Clock),
        .i_rst     (i_rst),
        .o_PgmAddr (pgmAddr),
        .i_PgmInst (pgmInst),
        .dataBus   (dataBus.master));

    ProgramRom #(
        .PC_WIDTH      (PC_WIDTH),
        .PGM_ADDR_BITS (PGM_ADDR_BITS))
    pgmMem (
        .i_Clock    (i_Clock),
        .i_WrEnable (i_PgmWrEnable),
        .i_WrAddr   (i_PgmWrAddr),
        .i_WrData   (i_PgmWrData),
        .i_Addr     (pgmAddr),
        .o_Inst     (pgmInst));

    DataRam #(
        .DATA_ADDR_BITS (DATA_ADDR_BITS))
    dataMem (
        .i_Clock (i_Clock),
        .bus     (dataBus.slave));

    // Store observation taps the write side of the bus
    assign o_StoreValid = dataBus.wrEnable;
    assign o_StoreAddr  = dataBus.addr;
    assign o_StoreData  = dataBus.wrData;

endmodule

//--- tb/tbProcessorSys.sv
// Processor system testbench
`timescale 1ns/1ps

module tbProcessorSys;

    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opJalr  = 7'b1100111;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    logic        clk;
    logic        rst;
    logic        pgmWrEnable;
    logic [7:0]  pgmWrAddr;
    logic [31:0] pgmWrData;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    integer      seed = 32'hdd485853;
    logic [31:0] prog [$];       // Program under assembly
    logic [31:0] expAddr [$];    // Expected stores, program order
    logic [31:0] expData [$];

    ProcessorSys dut_i (
        .i_Clock       (clk),
        .i_rst         (rst),
        .i_PgmWrEnable (pgmWrEnable),
        .i_PgmWrAddr   (pgmWrAddr),
        .i_PgmWrData   (pgmWrData),
        .o_StoreValid  (storeValid),
        .o_StoreAddr   (storeAddr),
        .o_StoreData   (storeData));

    always #4 clk = ~clk;        // 8 ns period

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] pcNow();
        return 32'(prog.size()) * 32'd4;  // Address of the next emitted word
    endfunction

    // RV32I result rules, funct3 plus the funct7 bit 30 selector
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: aluRef = alt ? a - b : a + b;
            3'd1: aluRef = a << sh;
            3'd2: aluRef = {31'd0, $signed(a) < $signed(b)};
            3'd3: aluRef = {31'd0, a < b};
            3'd4: aluRef = a ^ b;
            3'd5: begin
                if (alt)
                    aluRef = $signed(a) >>> sh;  // Sign fill
                else
                    aluRef = a >> sh;
            end
            3'd6: aluRef = a | b;
            default: aluRef = a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Instruction encoders
    task automatic rFormat(input logic [6:0] f7, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back({f7, rs2, rs1, f3, rd, 7'b0110011});
    endtask

    task automatic iFormat(input logic [6:0] op, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, f3, rd, op});
    endtask

    task automatic sFormat(input logic [4:0] rs2, input logic [11:0] addr);  // SW, base x0
        prog.push_back({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'b0100011});
    endtask

    task automatic bFormat(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [12:0] off);
        prog.push_back({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011});
    endtask

    task automatic uFormat(input logic [6:0] op, input logic [4:0] rd, input logic [19:0] up);
        prog.push_back({up, rd, op});
    endtask

    task automatic jFormat(input logic [4:0] rd, input logic [20:0] off);
        prog.push_back({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111});
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic storeResult(input logic [4:0] rs, input logic [11:0] addr,
                               input logic [31:0] data);
        sFormat(rs, addr);
        expectStore({20'd0, addr}, data);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Program goes in under reset, then the CPU starts from address 0
    task automatic loadProgram();
        jFormat(5'd0, 21'd0);                 // Park on a self jump
        @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (prog[i]) begin
            pgmWrEnable = 1'b1;
            pgmWrAddr   = 8'(i);
            pgmWrData   = prog[i];
            @(posedge clk);
            #1;
        end
        pgmWrEnable = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        prog.delete();
    endtask

    task automatic awaitStore(input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!storeValid) begin
            cycles++;
            if (cycles > 500) begin
                $display("Timeout: no store appeared while waiting for a write to %h", addr);
                $display("TEST FAILED");
                $fatal(1, "Store timeout");
            end
            @(negedge clk);
        end
        checkValue("o_StoreAddr", storeAddr, addr);
        checkValue("o_StoreData", storeData, data);
        @(posedge clk);                       // Store completes here
    endtask

    task automatic checkStores();
        while (expAddr.size() > 0)
            awaitStore(expAddr.pop_front(), expData.pop_front());
        repeat (20) begin                     // Nothing more may be written
            @(negedge clk);
            if (storeValid) begin
                $display("Unexpected store to %h after the last expected one", storeAddr);
                $display("TEST FAILED");
                $fatal(1, "Extra store");
            end
        end
    endtask

    task automatic testAluOps();
        logic [31:0] a, b, rnd, imm;
        logic [11:0] addr;
        logic [2:0]  f3;
        addr = 12'h000;
        for (int pair = 0; pair < 3; pair++) begin
            rnd     = $random(seed);
            rnd[11] = pair[0];                               // Sign of x1 alternates
            a       = sext12(rnd[11:0]);
            iFormat(opImm, 3'd0, 5'd1, 5'd0, rnd[11:0]);     // ADDI x1
            rnd     = $random(seed);
            rnd[31] = ~pair[0];                              // x2 sign opposite to x1
            b       = {rnd[31:12], 12'd0} + sext12(rnd[11:0]);
            uFormat(opLui, 5'd2, rnd[31:12]);                // LUI then ADDI x2
            iFormat(opImm, 3'd0, 5'd2, 5'd2, rnd[11:0]);
            for (int op = 0; op < 10; op++) begin           // 8 and 9 are SUB and SRA
                f3 = op < 8 ? 3'(op) : (op == 8 ? 3'd0 : 3'd5);
                rFormat(op >= 8 ? 7'b0100000 : 7'd0, f3, 5'd3, 5'd1, 5'd2);
                storeResult(5'd3, addr, aluRef(f3, op >= 8, a, b));
                addr = addr + 12'd4;
            end
            for (int op = 0; op < 9; op++) begin            // 8 is SRAI
                f3  = op < 8 ? 3'(op) : 3'd5;
                rnd = $random(seed);
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {20'd0, (op == 8) ? 7'b0100000 : 7'd0, rnd[4:0]};
                else
                    imm = sext12(rnd[11:0]);
                iFormat(opImm, f3, 5'd4, 5'd1, imm[11:0]);
                storeResult(5'd4, addr, aluRef(f3, op == 8, a, imm));
                addr = addr + 12'd4;
            end
        end
        loadProgram();
        checkStores();
    endtask

    task automatic testMemory();
        logic [31:0] a, b, rnd;
        rnd = $random(seed);
        a   = sext12(rnd[11:0]);
        iFormat(opImm, 3'd0, 5'd1, 5'd0, rnd[11:0]);
        rnd = $random(seed);
        b   = {rnd[31:12], 12'd0};
        uFormat(opLui, 5'd2, rnd[31:12]);
        storeResult(5'd1, 12'h200, a);
        storeResult(5'd2, 12'h204, b);
        iFormat(opLoad, 3'b010, 5'd5, 5'd0, 12'h200);        // LW x5
        iFormat(opLoad, 3'b010, 5'd6, 5'd0, 12'h204);        // LW x6
        rFormat(7'd0, 3'd0, 5'd7, 5'd5, 5'd6);
        storeResult(5'd7, 12'h208, a + b);                   // Sum of the originals
        loadProgram();
        checkStores();
    endtask

    task automatic testBranches();
        logic [4:0]  lhs [3];
        logic [4:0]  rhs [3];
        logic [31:0] va, vb;
        logic [11:0] addr;
        logic [2:0]  f3;
        lhs  = '{5'd10, 5'd11, 5'd11};
        rhs  = '{5'd11, 5'd10, 5'd12};
        addr = 12'h300;
        iFormat(opImm, 3'd0, 5'd10, 5'd0, 12'hFFD);          // x10 = -3
        iFormat(opImm, 3'd0, 5'd11, 5'd0, 12'd7);
        iFormat(opImm, 3'd0, 5'd12, 5'd0, 12'd7);
        for (int k = 0; k < 6; k++) begin
            f3 = k < 2 ? 3'(k) : 3'(k + 2);                  // BEQ BNE BLT BGE BLTU BGEU
            for (int p = 0; p < 3; p++) begin
                va = lhs[p] == 5'd10 ? 32'hFFFFFFFD : 32'd7;
                vb = rhs[p] == 5'd10 ? 32'hFFFFFFFD : 32'd7;
                bFormat(f3, lhs[p], rhs[p], 13'd8);          // Taken skips one store
                if (branchTaken(f3, va, vb))
                    sFormat(5'd11, addr);
                else
                    storeResult(5'd11, addr, 32'd7);
                storeResult(5'd11, addr + 12'd4, 32'd7);
                addr = addr + 12'd8;
            end
        end
        loadProgram();
        checkStores();
    endtask

    task automatic testJumps();
        logic [31:0] base;
        base = pcNow();
        jFormat(5'd5, 21'd12);                               // JAL x5, +12
        sFormat(5'd0, 12'h3A0);
        sFormat(5'd0, 12'h3A4);
        storeResult(5'd5, 12'h3A8, base + 32'd4);
        base = pcNow();
        iFormat(opImm, 3'd0, 5'd6, 5'd0, 12'(base + 32'd17)); // Odd target, bit 0 dropped
        iFormat(opJalr, 3'd0, 5'd7, 5'd6, 12'd0);
        sFormat(5'd0, 12'h3AC);
        sFormat(5'd0, 12'h3B0);
        storeResult(5'd7, 12'h3B4, base + 32'd8);            // Link of the JALR at base+4
        loadProgram();
        checkStores();
    endtask

    task automatic testUpperAndZero();
        logic [31:0] rnd, at;
        rnd = $random(seed);
        iFormat(opImm, 3'd0, 5'd0, 5'd0, 12'h123);           // Both aimed at x0
        uFormat(opLui, 5'd0, rnd[31:12]);
        storeResult(5'd0, 12'h3C4, 32'd0);
        at  = pcNow();                                       // AUIPC away from address 0
        uFormat(opAuipc, 5'd8, rnd[19:0]);
        storeResult(5'd8, 12'h3C0, at + {rnd[19:0], 12'd0});
        iFormat(opImm, 3'd0, 5'd9, 5'd0, 12'd55);
        rnd = $random(seed);
        prog.push_back({rnd[31:12], 5'd9, 7'b1111111});      // Unknown opcode, rd field x9
        storeResult(5'd9, 12'h3C8, 32'd55);
        loadProgram();
        checkStores();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        pgmWrEnable = 1'b0;
        pgmWrAddr   = '0;
        pgmWrData   = '0;
        testAluOps();
        testMemory();
        testBranches();
        testJumps();
        testUpperAndZero();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- project.f
source/rvTypes.sv
source/memBus.sv
source/Controller_RV32I.sv
source/Decoder_RV32I.sv
source/RegisterFile.sv
source/Alu.sv
source/ProcessorSC.sv
source/ProgramRom.sv
source/DataRam.sv
source/ProcessorSys.sv
tb/tbProcessorSys.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tbProcessorSys -f project.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "Simulation run OK" || { echo "Simulation run failed"; exit 1; }
